//--- Makefile
TOP := tb_wb_soc_fabric

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f src.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- rtl/sw_led_port.sv
`default_nettype none

`include "wb_soc_macros.svh"

module sw_led_port (
    input  wire                      i_clk,
    input  wire                      i_arst_n,
    input  wire                      i_stb,
    input  wire wb_soc_pkg::wb_req_t i_req,
    output logic                     o_ack,
    output logic [`WB_DW-1:0]        o_data,
    input  wire [15:0]               i_switches,
    output logic [15:0]              o_leds
);

    logic [15:0] r_leds;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_ack  <= 1'b0;
            r_leds <= '0;
        end else begin
            o_ack <= i_stb;
            // only the two low byte lanes reach the leds
            if (i_stb && i_req.we) begin
                if (i_req.sel[0]) begin
                    r_leds[7:0] <= i_req.data[7:0];
                end
                if (i_req.sel[1]) begin
                    r_leds[15:8] <= i_req.data[15:8];
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_stb) begin
            o_data <= {r_leds, i_switches};
        end
    end

    assign o_leds = r_leds;

endmodule

`default_nettype wire

//--- rtl/sys_regs.sv
`default_nettype none

`include "wb_soc_macros.svh"

module sys_regs (
    input  wire                        i_clk,
    input  wire                        i_arst_n,
    input  wire                        i_stb,
    input  wire wb_soc_pkg::wb_req_t   i_req,
    input  wire wb_soc_pkg::bus_fault_t i_fault,
    output logic                       o_ack,
    output logic [`WB_DW-1:0]          o_data,
    output logic                       o_irq
);

    logic [3:0]        w_offset;
    logic [`WB_DW-1:0] r_scratch;
    logic [`WB_AW-1:0] r_fault_addr;
    logic [`WB_DW-1:0] r_uptime;
    logic              r_irq;

    // the whole page aliases every 16 words
    assign w_offset = i_req.addr[3:0];

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_ack    <= 1'b0;
            r_irq    <= 1'b0;
            r_uptime <= '0;
        end else begin
            o_ack <= i_stb;
            if (i_stb && i_req.we && (w_offset == 4'd4)) begin
                r_irq <= i_req.data[0];
            end
            // top bit sticks once reached while the low bits keep counting
            if (!r_uptime[`WB_DW-1]) begin
                r_uptime <= r_uptime + 1'b1;
            end else begin
                r_uptime[`WB_DW-2:0] <= r_uptime[`WB_DW-2:0] + 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_stb && i_req.we && (w_offset == 4'd1)) begin
            r_scratch <= i_req.data;
        end
        if (i_fault.valid) begin
            r_fault_addr <= i_fault.addr;
        end
        if (i_stb) begin
            case (w_offset)
                4'd0:    o_data <= `SYS_ID_WORD;
                4'd1:    o_data <= r_scratch;
                4'd2:    o_data <= {r_fault_addr, 2'b00};
                4'd3:    o_data <= r_uptime;
                4'd4:    o_data <= {{(`WB_DW-1){1'b0}}, r_irq};
                default: o_data <= '0;
            endcase
        end
    end

    assign o_irq = r_irq;

endmodule

`default_nettype wire

//--- rtl/wb_addr_decode.sv
`default_nettype none

`include "wb_soc_macros.svh"

module wb_addr_decode (
    input  wire                      i_clk,
    input  wire                      i_arst_n,
    input  wire wb_soc_pkg::wb_req_t i_req,
    output wb_soc_pkg::wb_rsp_t      o_rsp,
    output logic                     o_ram_stb,
    output logic                     o_sys_stb,
    output logic                     o_swled_stb,
    input  wire                      i_ram_ack,
    input  wire                      i_sys_ack,
    input  wire                      i_swled_ack,
    input  wire [`WB_DW-1:0]         i_ram_data,
    input  wire [`WB_DW-1:0]         i_sys_data,
    input  wire [`WB_DW-1:0]         i_swled_data,
    output wb_soc_pkg::bus_fault_t   o_fault
);
    import wb_soc_pkg::*;

    wb_addr_u          w_addr;
    logic              w_stb;
    logic              w_none_sel;
    logic              r_fault_valid;
    logic [`WB_AW-1:0] r_fault_addr;
    logic              r_ack;
    logic              r_err;
    logic [`WB_DW-1:0] r_data;

    assign w_addr.word = i_req.addr;
    assign w_stb       = i_req.cyc && i_req.stb;

    assign o_ram_stb   = w_stb && (w_addr.paged.page == `PAGE_RAM);
    assign o_sys_stb   = w_stb && (w_addr.paged.page == `PAGE_SYS);
    assign o_swled_stb = w_stb && (w_addr.word == `SWLED_ADDR);
    assign w_none_sel  = !(o_ram_stb || o_sys_stb || o_swled_stb);

    // fault stage lines up with the slave ack stage
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            r_fault_valid <= 1'b0;
            r_ack         <= 1'b0;
            r_err         <= 1'b0;
        end else begin
            r_fault_valid <= w_stb && w_none_sel;
            r_ack         <= i_ram_ack || i_sys_ack || i_swled_ack;
            r_err         <= r_fault_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (w_stb && w_none_sel) begin
            r_fault_addr <= i_req.addr;
        end
        if (i_sys_ack) begin
            r_data <= i_sys_data;
        end else if (i_ram_ack) begin
            r_data <= i_ram_data;
        end else if (i_swled_ack) begin
            r_data <= i_swled_data;
        end else begin
            r_data <= '0;
        end
    end

    assign o_fault = '{valid: r_fault_valid, addr: r_fault_addr};

    // slaves never stall, so the main bus never does
    assign o_rsp = '{ack: r_ack, stall: 1'b0, err: r_err, data: r_data};

    a_one_slave: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        $onehot0({o_ram_stb, o_sys_stb, o_swled_stb}))
        else $error("more than one slave strobed");

    // every strobe on the main bus ends in exactly one ack or err
    a_resp_latency: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        w_stb |=> ##1 (o_rsp.ack != o_rsp.err))
        else $error("main bus response missing two cycles after strobe");

endmodule

`default_nettype wire

//--- rtl/wb_pri_arbiter.sv
`default_nettype none

module wb_pri_arbiter (
    input  wire                   i_clk,
    input  wire                   i_arst_n,
    input  wire wb_soc_pkg::wb_req_t i_a_req,
    input  wire wb_soc_pkg::wb_req_t i_b_req,
    output wb_soc_pkg::wb_rsp_t   o_a_rsp,
    output wb_soc_pkg::wb_rsp_t   o_b_rsp,
    output wb_soc_pkg::wb_req_t   o_req,
    input  wire wb_soc_pkg::wb_rsp_t i_rsp
);
    import wb_soc_pkg::*;

    // 0 means master a owns the downstream bus
    logic    r_owner_b;
    logic    w_held;
    logic    w_owner_b;
    wb_req_t w_sel_req;

    // current owner still holds cyc, so no new arbitration
    assign w_held = r_owner_b ? i_b_req.cyc : i_a_req.cyc;

    // a wins whenever the bus is free
    assign w_owner_b = w_held ? r_owner_b : (!i_a_req.cyc && i_b_req.cyc);

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            r_owner_b <= 1'b0;
        end else begin
            r_owner_b <= w_owner_b;
        end
    end

    assign w_sel_req = w_owner_b ? i_b_req : i_a_req;

    always_comb begin
        o_req     = w_sel_req;
        // no strobe leaks out without a cycle
        o_req.stb = w_sel_req.cyc && w_sel_req.stb;
    end

    // responses follow the owner, read data goes to both
    always_comb begin
        o_a_rsp.data  = i_rsp.data;
        o_a_rsp.ack   = !w_owner_b && i_rsp.ack;
        o_a_rsp.err   = !w_owner_b && i_rsp.err;
        o_a_rsp.stall = w_owner_b ? i_a_req.stb : i_rsp.stall;

        o_b_rsp.data  = i_rsp.data;
        o_b_rsp.ack   = w_owner_b && i_rsp.ack;
        o_b_rsp.err   = w_owner_b && i_rsp.err;
        o_b_rsp.stall = w_owner_b ? i_rsp.stall : i_b_req.stb;
    end

    // ownership is kept across cycles while the owner holds cyc
    a_owner_stable: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_req.cyc |=> (!w_held || (w_owner_b == $past(w_owner_b))))
        else $error("arbiter owner changed during a held cycle");

    // a response only ever reaches a master that holds its cycle
    a_no_stray_ack: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        ((o_a_rsp.ack || o_a_rsp.err) |-> i_a_req.cyc) and
        ((o_b_rsp.ack || o_b_rsp.err) |-> i_b_req.cyc))
        else $error("response routed to a master without cyc");

endmodule

`default_nettype wire

//--- rtl/wb_ram.sv
`default_nettype none

`include "wb_soc_macros.svh"

module wb_ram (
    input  wire                      i_clk,
    input  wire                      i_stb,
    input  wire wb_soc_pkg::wb_req_t i_req,
    output logic                     o_ack,
    output logic [`WB_DW-1:0]        o_data
);

    localparam int RAM_AW = $clog2(`RAM_WORDS);
    localparam int BYTE_W = `WB_DW / `WB_SW;

    logic [`WB_DW-1:0] mem [`RAM_WORDS];
    logic [RAM_AW-1:0] w_idx;

    // upper address bits are ignored, so page 0 wraps onto the array
    assign w_idx = i_req.addr[RAM_AW-1:0];

    // byte lane writes
    always_ff @(posedge i_clk) begin
        if (i_stb && i_req.we) begin
            for (int b = 0; b < `WB_SW; b++) begin
                if (i_req.sel[b]) begin
                    mem[w_idx][BYTE_W*b +: BYTE_W] <= i_req.data[BYTE_W*b +: BYTE_W];
                end
            end
        end
    end

    // read returns the word as it was before a same-cycle write
    always_ff @(posedge i_clk) begin
        if (i_stb) begin
            o_data <= mem[w_idx];
        end
        o_ack <= i_stb;
    end

endmodule

`default_nettype wire

//--- rtl/wb_soc_fabric.sv
`default_nettype none

`include "wb_soc_macros.svh"

// data master beats instruction master on the internal bus,
// internal bus beats debug master on the main bus
module wb_soc_fabric (
    input  wire                      i_clk,
    input  wire                      i_arst_n,
    input  wire wb_soc_pkg::wb_req_t i_dbus_req,
    output wb_soc_pkg::wb_rsp_t      o_dbus_rsp,
    input  wire wb_soc_pkg::wb_req_t i_ibus_req,
    output wb_soc_pkg::wb_rsp_t      o_ibus_rsp,
    input  wire wb_soc_pkg::wb_req_t i_dbg_req,
    output wb_soc_pkg::wb_rsp_t      o_dbg_rsp,
    input  wire [15:0]               i_switches,
    output logic [15:0]              o_leds,
    output logic                     o_irq
);
    import wb_soc_pkg::*;

    wb_req_t           ibus_req;
    wb_rsp_t           ibus_rsp;
    wb_req_t           mbus_req;
    wb_rsp_t           mbus_rsp;
    bus_fault_t        fault;
    logic              ram_stb;
    logic              sys_stb;
    logic              swled_stb;
    logic              ram_ack;
    logic              sys_ack;
    logic              swled_ack;
    logic [`WB_DW-1:0] ram_data;
    logic [`WB_DW-1:0] sys_data;
    logic [`WB_DW-1:0] swled_data;

    wb_pri_arbiter u_ibus_arb (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_a_req  (i_dbus_req),
        .i_b_req  (i_ibus_req),
        .o_a_rsp  (o_dbus_rsp),
        .o_b_rsp  (o_ibus_rsp),
        .o_req    (ibus_req),
        .i_rsp    (ibus_rsp)
    );

    wb_pri_arbiter u_mbus_arb (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_a_req  (ibus_req),
        .i_b_req  (i_dbg_req),
        .o_a_rsp  (ibus_rsp),
        .o_b_rsp  (o_dbg_rsp),
        .o_req    (mbus_req),
        .i_rsp    (mbus_rsp)
    );

    wb_addr_decode u_decode (
        .i_clk        (i_clk),
        .i_arst_n     (i_arst_n),
        .i_req        (mbus_req),
        .o_rsp        (mbus_rsp),
        .o_ram_stb    (ram_stb),
        .o_sys_stb    (sys_stb),
        .o_swled_stb  (swled_stb),
        .i_ram_ack    (ram_ack),
        .i_sys_ack    (sys_ack),
        .i_swled_ack  (swled_ack),
        .i_ram_data   (ram_data),
        .i_sys_data   (sys_data),
        .i_swled_data (swled_data),
        .o_fault      (fault)
    );

    wb_ram u_ram (
        .i_clk  (i_clk),
        .i_stb  (ram_stb),
        .i_req  (mbus_req),
        .o_ack  (ram_ack),
        .o_data (ram_data)
    );

    sys_regs u_sys_regs (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_stb    (sys_stb),
        .i_req    (mbus_req),
        .i_fault  (fault),
        .o_ack    (sys_ack),
        .o_data   (sys_data),
        .o_irq    (o_irq)
    );

    sw_led_port u_sw_led (
        .i_clk      (i_clk),
        .i_arst_n   (i_arst_n),
        .i_stb      (swled_stb),
        .i_req      (mbus_req),
        .o_ack      (swled_ack),
        .o_data     (swled_data),
        .i_switches (i_switches),
        .o_leds     (o_leds)
    );

endmodule

`default_nettype wire

//--- rtl/wb_soc_macros.svh
`ifndef WB_SOC_MACROS_SVH
`define WB_SOC_MACROS_SVH

// bus widths, data and select are byte lanes of the data word
`define WB_DW 32
`define WB_AW 30
`define WB_SW 4

// top bits of the word address pick the slave page
`define WB_PAGE_W 9

// on-chip ram depth in words
`define RAM_WORDS 1024

// value returned by the system register block at offset 0
`define SYS_ID_WORD 32'h57B5_0C01

// page map of the main bus
`define PAGE_RAM 9'd0
`define PAGE_SYS 9'd1

// switch/led port sits alone on page 2
`define SWLED_ADDR 30'h0040_0001

`endif

//--- rtl/wb_soc_pkg.sv
`default_nettype none

`include "wb_soc_macros.svh"

package wb_soc_pkg;

    // master side of a pipelined wishbone port
    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic                we;
        logic [`WB_AW-1:0]   addr;
        logic [`WB_DW-1:0]   data;
        logic [`WB_SW-1:0]   sel;
    } wb_req_t;

    // slave side, data is valid together with ack
    typedef struct packed {
        logic                ack;
        logic                stall;
        logic                err;
        logic [`WB_DW-1:0]   data;
    } wb_rsp_t;

    // word address, read whole or split into page and offset
    typedef union packed {
        logic [`WB_AW-1:0] word;
        struct packed {
            logic [`WB_PAGE_W-1:0]        page;
            logic [`WB_AW-`WB_PAGE_W-1:0] offset;
        } paged;
    } wb_addr_u;

    // unmapped access report from the decoder
    typedef struct packed {
        logic                valid;
        logic [`WB_AW-1:0]   addr;
    } bus_fault_t;

endpackage

`default_nettype wire

//--- sim/tb_wb_soc_fabric.sv
`default_nettype none

`include "wb_soc_macros.svh"

module tb_wb_soc_fabric;
    timeunit 1ns;
    timeprecision 1ps;
    import wb_soc_pkg::*;

    // expected response of one accepted request
    typedef struct packed {
        logic        ack;
        logic        err;
        logic        chk;
        logic [31:0] data;
    } exp_t;

    logic        i_clk;
    logic        i_arst_n;
    logic [15:0] i_switches;
    logic [15:0] o_leds;
    logic        o_irq;
    wb_req_t     req [3];
    wb_rsp_t     rsp [3];
    exp_t        exp_cur [3];
    exp_t        pipe0 [3];
    exp_t        pipe1 [3];
    int          resp_cnt [3];
    logic [31:0] last_data [3];
    logic [31:0] ram_model [1024];

    // master 0 is data, 1 is instruction, 2 is debug
    wb_soc_fabric uut (
        .i_clk      (i_clk),
        .i_arst_n   (i_arst_n),
        .i_dbus_req (req[0]),
        .o_dbus_rsp (rsp[0]),
        .i_ibus_req (req[1]),
        .o_ibus_rsp (rsp[1]),
        .i_dbg_req  (req[2]),
        .o_dbg_rsp  (rsp[2]),
        .i_switches (i_switches),
        .o_leds     (o_leds),
        .o_irq      (o_irq)
    );

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    task automatic stop_run();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_rsp(int m, exp_t e, wb_rsp_t r);
        string act;
        act = $sformatf("actual ack=%b err=%b data=%h", r.ack, r.err, r.data);
        $display("Error: time %0t signal rsp[%0d] expected ack=%b err=%b data=%h %s",
                 $time, m, e.ack, e.err, e.data, act);
        stop_run();
    endtask

    task automatic report_plain(string msg);
        $display("Error: time %0t %s", $time, msg);
        stop_run();
    endtask

    task automatic check_val(string name, logic [31:0] expv, logic [31:0] actv);
        if (expv !== actv) begin
            $display("Error: time %0t signal %s expected %h actual %h", $time, name, expv, actv);
            stop_run();
        end
    endtask

    // acceptance moves the expected response two stages down
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int m = 0; m < 3; m++) begin
                pipe0[m]    <= '0;
                pipe1[m]    <= '0;
                resp_cnt[m] <= 0;
            end
        end else begin
            for (int m = 0; m < 3; m++) begin
                pipe0[m] <= (req[m].cyc && req[m].stb && !rsp[m].stall) ? exp_cur[m] : '0;
                pipe1[m] <= pipe0[m];
                if (rsp[m].ack || rsp[m].err) begin
                    resp_cnt[m]  <= resp_cnt[m] + 1;
                    last_data[m] <= rsp[m].data;
                end
            end
        end
    end

    for (genvar g = 0; g < 3; g++) begin : g_chk
        a_rsp: assert property (@(posedge i_clk) disable iff (!i_arst_n)
            (rsp[g].ack == pipe1[g].ack) && (rsp[g].err == pipe1[g].err) &&
            (!(pipe1[g].ack && pipe1[g].chk) || (rsp[g].data == pipe1[g].data)))
            else report_rsp(g, $sampled(pipe1[g]), $sampled(rsp[g]));
    end

    // data master wins the internal bus, internal bus wins the main bus
    a_ibus_stall: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (req[0].cyc && req[1].stb) |-> rsp[1].stall)
        else report_plain("instruction master was not stalled behind the data master");

    a_dbg_stall: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        ((req[0].cyc || req[1].cyc) && req[2].stb) |-> rsp[2].stall)
        else report_plain("debug master was not stalled behind the internal bus");

    task automatic drive(int m, logic we, logic [29:0] addr, logic [31:0] data,
                         logic [3:0] sel, logic chk, logic err, logic [31:0] edata);
        logic stall;
        int   n;
        n = 0;
        @(negedge i_clk);
        req[m]     = '{cyc: 1'b1, stb: 1'b1, we: we, addr: addr, data: data, sel: sel};
        exp_cur[m] = '{ack: !err, err: err, chk: chk, data: edata};
        forever begin
            #1;
            stall = rsp[m].stall;
            @(posedge i_clk);
            if (!stall) break;
            n++;
            if (n > 50) report_plain("request was never accepted");
            @(negedge i_clk);
        end
    endtask

    task automatic end_stb(int m);
        @(negedge i_clk);
        req[m].stb = 1'b0;
    endtask

    task automatic wait_count(int m, int target);
        int n;
        n = 0;
        while (resp_cnt[m] < target) begin
            @(negedge i_clk);
            n++;
            if (n > 50) report_plain("no ack or err arrived");
        end
    endtask

    task automatic xfer(int m, logic we, logic [29:0] addr, logic [31:0] data, logic [3:0] sel,
                        logic chk, logic err, logic [31:0] edata, output logic [31:0] rdata);
        int target;
        target = resp_cnt[m] + 1;
        drive(m, we, addr, data, sel, chk, err, edata);
        end_stb(m);
        wait_count(m, target);
        rdata  = last_data[m];
        req[m] = '0;
    endtask

    function automatic logic [31:0] merge(logic [31:0] old, logic [31:0] d, logic [3:0] sel);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) res[8*b +: 8] = d[8*b +: 8];
        end
        return res;
    endfunction

    initial begin
        logic [31:0] d;
        logic [31:0] t0;
        logic [31:0] t1;
        logic [29:0] a;
        int          target;
        void'($urandom(51));
        for (int m = 0; m < 3; m++) begin
            req[m]     = '0;
            exp_cur[m] = '0;
        end
        i_switches = '0;
        i_arst_n   = 1'b0;
        repeat (5) @(posedge i_clk);
        @(negedge i_clk);
        i_arst_n = 1'b1;
        @(negedge i_clk);
        for (int m = 0; m < 3; m++) begin
            check_val("rsp ack/err/stall", 32'd0, {29'd0, rsp[m].ack, rsp[m].err, rsp[m].stall});
        end
        check_val("o_irq", 32'd0, {31'd0, o_irq});

        // ram write and readback through data and instruction ports
        for (int i = 0; i < 4; i++) begin
            a = 30'(i * 5 + 3);
            d = $urandom;
            ram_model[a] = d;
            xfer(0, 1'b1, a, d, 4'hf, 1'b0, 1'b0, 32'd0, t0);
        end
        d = $urandom;
        ram_model[3] = merge(ram_model[3], d, 4'b0101);
        xfer(0, 1'b1, 30'd3, d, 4'b0101, 1'b0, 1'b0, 32'd0, t0);
        for (int i = 0; i < 4; i++) begin
            a = 30'(i * 5 + 3);
            xfer(0, 1'b0, a, 32'd0, 4'hf, 1'b1, 1'b0, ram_model[a], t0);
            xfer(1, 1'b0, a, 32'd0, 4'hf, 1'b1, 1'b0, ram_model[a], t0);
        end

        // system registers
        xfer(0, 1'b0, 30'h200000, 32'd0, 4'hf, 1'b1, 1'b0, `SYS_ID_WORD, t0);
        d = $urandom;
        xfer(0, 1'b1, 30'h200001, d, 4'hf, 1'b0, 1'b0, 32'd0, t0);
        xfer(0, 1'b0, 30'h200001, 32'd0, 4'hf, 1'b1, 1'b0, d, t0);
        xfer(0, 1'b1, 30'h200004, 32'd1, 4'hf, 1'b0, 1'b0, 32'd0, t0);
        check_val("o_irq", 32'd1, {31'd0, o_irq});
        xfer(0, 1'b1, 30'h200004, 32'd0, 4'hf, 1'b0, 1'b0, 32'd0, t0);
        check_val("o_irq", 32'd0, {31'd0, o_irq});
        xfer(0, 1'b0, 30'h200003, 32'd0, 4'hf, 1'b0, 1'b0, 32'd0, t0);
        repeat (20) @(negedge i_clk);
        xfer(0, 1'b0, 30'h200003, 32'd0, 4'hf, 1'b0, 1'b0, 32'd0, t1);
        if (t1 <= t0) report_plain("uptime counter did not increase between reads");

        // unmapped page 2 word then the fault address as a byte address
        xfer(0, 1'b0, 30'h400010, 32'd0, 4'hf, 1'b0, 1'b1, 32'd0, t0);
        xfer(0, 1'b0, 30'h200002, 32'd0, 4'hf, 1'b1, 1'b0, {30'h400010, 2'b00}, t0);

        // switch and led port
        i_switches = 16'($urandom);
        d = $urandom;
        xfer(0, 1'b1, `SWLED_ADDR, d, 4'b0011, 1'b0, 1'b0, 32'd0, t0);
        check_val("o_leds", {16'd0, d[15:0]}, {16'd0, o_leds});
        xfer(2, 1'b0, `SWLED_ADDR, 32'd0, 4'hf, 1'b1, 1'b0, {d[15:0], i_switches}, t0);

        // same-cycle data and instruction requests
        fork
            xfer(0, 1'b0, 30'd8, 32'd0, 4'hf, 1'b1, 1'b0, ram_model[8], t0);
            xfer(1, 1'b0, 30'd13, 32'd0, 4'hf, 1'b1, 1'b0, ram_model[13], t1);
        join
        // debug strobes while the instruction master holds the bus
        fork
            xfer(1, 1'b0, 30'd3, 32'd0, 4'hf, 1'b1, 1'b0, ram_model[3], t0);
            begin
                @(negedge i_clk);
                xfer(2, 1'b0, 30'd18, 32'd0, 4'hf, 1'b1, 1'b0, ram_model[18], t1);
            end
        join

        // three reads in flight
        target = resp_cnt[0] + 3;
        drive(0, 1'b0, 30'd3, 32'd0, 4'hf, 1'b1, 1'b0, ram_model[3]);
        drive(0, 1'b0, 30'd8, 32'd0, 4'hf, 1'b1, 1'b0, ram_model[8]);
        drive(0, 1'b0, 30'h200000, 32'd0, 4'hf, 1'b1, 1'b0, `SYS_ID_WORD);
        end_stb(0);
        wait_count(0, target);
        req[0] = '0;
        repeat (3) @(negedge i_clk);

        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+rtl
rtl/wb_soc_pkg.sv
rtl/wb_pri_arbiter.sv
rtl/wb_addr_decode.sv
rtl/wb_ram.sv
rtl/sys_regs.sv
rtl/sw_led_port.sv
rtl/wb_soc_fabric.sv
sim/tb_wb_soc_fabric.sv
